//--- source/memSysPkg.sv
package memSysPkg;

    ////////////////////
    // Widths and address map

    typedef logic [31:0] word_t;

    localparam word_t PeriphBase  = 32'h0001_0000;
    localparam word_t PeriphLimit = 32'h0002_0000;

    localparam int PeriphLatency = 3;
    localparam int PeriphWords   = 16;
    localparam int MemLatency    = 4;
    localparam int MemWords      = 1024;
    localparam int CacheLines    = 64;

    // Word indices, all taken from address bit 2 upwards
    typedef logic [$clog2(PeriphWords)-1:0] periphIndex_t;
    typedef logic [$clog2(MemWords)-1:0]    memIndex_t;
    typedef logic [$clog2(CacheLines)-1:0]  cacheIndex_t;
    typedef logic [29-$clog2(CacheLines):0] cacheTag_t;

    // Latency counters
    typedef logic [$clog2(PeriphLatency+1)-1:0] periphCount_t;
    typedef logic [$clog2(MemLatency+1)-1:0]    memCount_t;

    ////////////////////
    // Requests and states

    typedef struct packed {
        logic  rw;
        word_t address;
        word_t writeData;
    } cpuReq_t;

    typedef struct packed {
        logic  en;
        logic  rw;
        word_t address;
        word_t writeData;
    } memReq_t;

    typedef enum logic [1:0] {PeriphIdle, PeriphStart, PeriphWait, PeriphDone} periphState_t;

    typedef enum logic [2:0] {
        CacheIdle, CacheFetch, CacheFill, CacheWrite, CacheDone
    } cacheState_t;

endpackage

//--- source/memController.sv
`timescale 1ns/10ps

module memController
    import memSysPkg::*;
(
    // CPU side
    input  logic    en,
    input  cpuReq_t req,
    output logic    stall,
    output word_t   oData,

    // Peripheral side
    output logic    pEn,
    input  logic    pStall,
    input  word_t   pReadData,

    // Cache side
    output memReq_t cacheReq,
    input  logic    cacheStall,
    input  word_t   cacheReadData
);

    logic periphAccess;
    logic memAccess;

    // Peripheral window is inclusive at both ends
    assign periphAccess = en && (req.address >= PeriphBase) && (req.address <= PeriphLimit);
    assign memAccess    = en && !periphAccess;

    assign pEn = periphAccess;

    assign cacheReq = '{
        en:        memAccess,
        rw:        req.rw,
        address:   req.address,
        writeData: req.writeData
    };

    // Return path, zeros when no access is active
    always_comb begin
        if (periphAccess) begin
            stall = pStall;
            oData = pReadData;
        end else if (memAccess) begin
            stall = cacheStall;
            oData = cacheReadData;
        end else begin
            stall = 1'b0;
            oData = '0;
        end
    end

endmodule

//--- source/periphController.sv
`timescale 1ns/10ps

module periphController
    import memSysPkg::*;
(
    input  logic Clk,
    input  logic reset,
    input  logic pEn,
    input  logic rw,
    output logic pStall,
    output logic startRead,
    output logic startWrite,
    input  logic readCompleted,
    input  logic writeCompleted
);

    periphState_t state;
    periphState_t nextState;
    logic         completed;

    // Completion pulse matching the direction of the pending access
    assign completed = rw ? writeCompleted : readCompleted;

    always_comb begin
        nextState = state;
        case (state)
            PeriphIdle: begin
                if (pEn) begin
                    nextState = PeriphStart;
                end
            end
            PeriphStart: begin
                nextState = PeriphWait;
            end
            PeriphWait: begin
                if (completed) begin
                    nextState = PeriphDone;
                end
            end
            PeriphDone: begin
                nextState = PeriphIdle;
            end
            default: begin
                nextState = PeriphIdle;
            end
        endcase
    end

    always_ff @(posedge Clk) begin
        if (reset) begin
            state <= PeriphIdle;
        end else begin
            state <= nextState;
        end
    end

    ////////////////////
    // Outputs

    // Start is a single cycle since the FSM never stays in Start
    assign startRead  = (state == PeriphStart) && !rw;
    assign startWrite = (state == PeriphStart) && rw;

    // Release the CPU only for the Done cycle
    assign pStall = pEn && (state != PeriphDone);

endmodule

//--- source/periphRegBlock.sv
`timescale 1ns/10ps

module periphRegBlock
    import memSysPkg::*;
(
    input  logic  Clk,
    input  logic  reset,
    input  logic  startRead,
    input  logic  startWrite,
    input  word_t address,
    input  word_t writeData,
    output word_t readData,
    output logic  readCompleted,
    output logic  writeCompleted
);

    word_t        regs [PeriphWords];
    periphIndex_t index;
    periphCount_t count;
    logic         busy;
    logic         isWrite;

    // Register select from the word address
    assign index = address[2 +: $bits(periphIndex_t)];

    // Completion lands PeriphLatency cycles after the start pulse.
    // The first cycle is spent loading the counter.
    always_ff @(posedge Clk) begin
        if (reset) begin
            busy           <= 1'b0;
            isWrite        <= 1'b0;
            count          <= '0;
            readCompleted  <= 1'b0;
            writeCompleted <= 1'b0;
            readData       <= '0;
            for (int i = 0; i < PeriphWords; i++) begin
                regs[i] <= '0;
            end
        end else begin
            readCompleted  <= 1'b0;
            writeCompleted <= 1'b0;

            if (!busy) begin
                if (startRead || startWrite) begin
                    busy    <= 1'b1;
                    isWrite <= startWrite;
                    count   <= periphCount_t'(PeriphLatency - 1);
                end
            end else if (count == periphCount_t'(1)) begin
                busy <= 1'b0;
                if (isWrite) begin
                    regs[index]    <= writeData;
                    writeCompleted <= 1'b1;
                end else begin
                    // Held until the next read finishes
                    readData      <= regs[index];
                    readCompleted <= 1'b1;
                end
            end else begin
                count <= count - 1'b1;
            end
        end
    end

endmodule

//--- source/dataCache.sv
`timescale 1ns/10ps

module dataCache
    import memSysPkg::*;
(
    input  logic    Clk,
    input  logic    reset,

    // Controller side
    input  memReq_t cacheReq,
    output logic    cacheStall,
    output word_t   cacheReadData,

    // Main memory side
    output memReq_t memReq,
    input  logic    memDone,
    input  word_t   memReadData
);

    cacheState_t state;
    cacheState_t nextState;

    cacheTag_t             tagArr  [CacheLines];
    word_t                 dataArr [CacheLines];
    logic [CacheLines-1:0] validBits;

    cacheIndex_t index;
    cacheTag_t   tag;
    logic        hit;
    logic        readHit;
    logic        memIssue;

    ////////////////////
    // Lookup

    assign index = cacheReq.address[2 +: $bits(cacheIndex_t)];
    assign tag   = cacheReq.address[31 -: $bits(cacheTag_t)];
    assign hit   = validBits[index] && (tagArr[index] == tag);

    // Read hits complete in the cycle they are presented
    assign readHit = (state == CacheIdle) && cacheReq.en && !cacheReq.rw && hit;

    ////////////////////
    // Miss and write FSM

    always_comb begin
        nextState = state;
        case (state)
            CacheIdle: begin
                if (cacheReq.en) begin
                    if (cacheReq.rw) begin
                        nextState = CacheWrite;
                    end else if (!hit) begin
                        nextState = CacheFetch;
                    end
                end
            end
            CacheFetch: begin
                if (memDone) begin
                    nextState = CacheFill;
                end
            end
            CacheFill: begin
                nextState = CacheDone;
            end
            CacheWrite: begin
                if (memDone) begin
                    nextState = CacheDone;
                end
            end
            CacheDone: begin
                nextState = CacheIdle;
            end
            default: begin
                nextState = CacheIdle;
            end
        endcase
    end

    always_ff @(posedge Clk) begin
        if (reset) begin
            state     <= CacheIdle;
            validBits <= '0;
        end else begin
            state <= nextState;
            if (state == CacheFill) begin
                validBits[index] <= 1'b1;
            end
        end
    end

    // Line update on fill, or on a write that hits
    always_ff @(posedge Clk) begin
        if (state == CacheFill) begin
            tagArr[index]  <= tag;
            dataArr[index] <= memReadData;
        end else if ((state == CacheIdle) && cacheReq.en && cacheReq.rw && hit) begin
            dataArr[index] <= cacheReq.writeData;
        end
    end

    ////////////////////
    // Outputs

    // One memory pulse per miss or write, issued while leaving Idle
    assign memIssue = (state == CacheIdle) && cacheReq.en && (cacheReq.rw || !hit);

    assign memReq = '{
        en:        memIssue,
        rw:        cacheReq.rw,
        address:   cacheReq.address,
        writeData: cacheReq.writeData
    };

    assign cacheStall = cacheReq.en && !readHit && (state != CacheDone);

    assign cacheReadData = (cacheReq.en && !cacheReq.rw && !cacheStall) ? dataArr[index] : '0;

endmodule

//--- source/mainMemory.sv
`timescale 1ns/10ps

module mainMemory
    import memSysPkg::*;
(
    input  logic    Clk,
    input  logic    reset,
    input  memReq_t memReq,
    output logic    memDone,
    output word_t   memReadData
);

    word_t     mem [MemWords];
    memCount_t count;
    memIndex_t pendingIndex;
    word_t     pendingData;
    logic      pendingWrite;
    logic      busy;
    logic      fire;

    // Memory starts out cleared
    initial begin
        for (int i = 0; i < MemWords; i++) begin
            mem[i] = '0;
        end
    end

    // Last cycle of the latency window
    assign fire = busy && (count == memCount_t'(1));

    always_ff @(posedge Clk) begin
        if (reset) begin
            busy    <= 1'b0;
            count   <= '0;
            memDone <= 1'b0;
        end else begin
            memDone <= fire;
            if (!busy && memReq.en) begin
                busy  <= 1'b1;
                count <= memCount_t'(MemLatency - 1);
            end else if (fire) begin
                busy <= 1'b0;
            end else if (busy) begin
                count <= count - 1'b1;
            end
        end
    end

    // Request capture and array access
    always_ff @(posedge Clk) begin
        if (!busy && memReq.en) begin
            pendingIndex <= memReq.address[2 +: $bits(memIndex_t)];
            pendingData  <= memReq.writeData;
            pendingWrite <= memReq.rw;
        end
        if (fire) begin
            if (pendingWrite) begin
                mem[pendingIndex] <= pendingData;
            end else begin
                memReadData <= mem[pendingIndex];
            end
        end
    end

endmodule

//--- source/memSubsystem.sv
`timescale 1ns/10ps

module memSubsystem
    import memSysPkg::*;
(
    input  logic    Clk,
    input  logic    reset,
    input  logic    en,
    input  cpuReq_t req,
    output logic    stall,
    output word_t   oData
);

    logic    pEn;
    logic    pStall;
    word_t   pReadData;
    logic    startRead;
    logic    startWrite;
    logic    readCompleted;
    logic    writeCompleted;

    memReq_t cacheReq;
    logic    cacheStall;
    word_t   cacheReadData;

    memReq_t memReq;
    logic    memDone;
    word_t   memReadData;

    memController i_memController (
        .en            (en),
        .req           (req),
        .stall         (stall),
        .oData         (oData),
        .pEn           (pEn),
        .pStall        (pStall),
        .pReadData     (pReadData),
        .cacheReq      (cacheReq),
        .cacheStall    (cacheStall),
        .cacheReadData (cacheReadData)
    );

    ////////////////////
    // Peripheral path

    periphController i_periphController (
        .Clk            (Clk),
        .reset          (reset),
        .pEn            (pEn),
        .rw             (req.rw),
        .pStall         (pStall),
        .startRead      (startRead),
        .startWrite     (startWrite),
        .readCompleted  (readCompleted),
        .writeCompleted (writeCompleted)
    );

    // Address and data come straight from the CPU request
    periphRegBlock i_periphRegBlock (
        .Clk            (Clk),
        .reset          (reset),
        .startRead      (startRead),
        .startWrite     (startWrite),
        .address        (req.address),
        .writeData      (req.writeData),
        .readData       (pReadData),
        .readCompleted  (readCompleted),
        .writeCompleted (writeCompleted)
    );

    ////////////////////
    // Memory path

    dataCache i_dataCache (
        .Clk           (Clk),
        .reset         (reset),
        .cacheReq      (cacheReq),
        .cacheStall    (cacheStall),
        .cacheReadData (cacheReadData),
        .memReq        (memReq),
        .memDone       (memDone),
        .memReadData   (memReadData)
    );

    mainMemory i_mainMemory (
        .Clk         (Clk),
        .reset       (reset),
        .memReq      (memReq),
        .memDone     (memDone),
        .memReadData (memReadData)
    );

endmodule

//--- bench/memSubsystemTb.sv
`timescale 1ns/10ps

module memSubsystemTb
    import memSysPkg::*;
();

    localparam int Period      = 8;
    localparam int RandomOps   = 200;
    localparam int NumAccesses = RandomOps + 60;

    logic    Clk;
    logic    reset;
    logic    en;
    cpuReq_t req;
    logic    stall;
    word_t   oData;

    // Reference model, aliased by the word index rules
    word_t periphModel [PeriphWords];
    word_t memModel    [MemWords];

    logic [15:0] lfsrState;
    int          errors;
    int          checks;
    int          lastCycles;
    logic        lastSawStall;
    word_t       lastData;

    memSubsystem i_memSubsystem (
        .Clk   (Clk),
        .reset (reset),
        .en    (en),
        .req   (req),
        .stall (stall),
        .oData (oData)
    );

    always #(Period / 2) Clk = ~Clk;

    ////////////////////
    // Helpers

    // 16 bit Fibonacci LFSR, taps 16 14 13 11
    function automatic word_t randomBits(input int width);
        word_t value;
        logic  feedback;
        value = '0;
        for (int i = 0; i < width; i++) begin
            feedback  = lfsrState[15] ^ lfsrState[13] ^ lfsrState[12] ^ lfsrState[10];
            lfsrState = {lfsrState[14:0], feedback};
            value     = {value[30:0], feedback};
        end
        return value;
    endfunction

    function automatic logic inPeriph(input word_t address);
        return (address >= 32'h0001_0000) && (address <= 32'h0002_0000);
    endfunction

    function automatic word_t expectedRead(input word_t address);
        if (inPeriph(address)) begin
            return periphModel[address[5:2]];
        end
        return memModel[address[11:2]];
    endfunction

    function automatic void modelWrite(input word_t address, input word_t data);
        if (inPeriph(address)) begin
            periphModel[address[5:2]] = data;
        end else begin
            memModel[address[11:2]] = data;
        end
    endfunction

    task automatic checkValue(input string name, input word_t got, input word_t expected);
        checks++;
        assert (got === expected) else begin
            errors++;
            $display("mismatch %s: got 0x%08h, expected 0x%08h at %0t", name, got, expected,
                $time);
        end
    endtask

    task automatic expectTrue(input logic cond, input string what);
        checks++;
        assert (cond) else begin
            errors++;
            $display("%s at %0t", what, $time);
        end
    endtask

    // Holds the request until a rising edge sees Stall low
    task automatic access(input logic rw, input word_t address, input word_t data);
        logic finished;
        @(negedge Clk);
        en            = 1'b1;
        req.rw        = rw;
        req.address   = address;
        req.writeData = data;
        lastCycles    = 0;
        lastSawStall  = 1'b0;
        finished      = 1'b0;
        while (!finished) begin
            // Sample in the low phase, clear of both edges
            #(Period / 4);
            lastCycles++;
            if (stall) begin
                lastSawStall = 1'b1;
                @(negedge Clk);
            end else begin
                lastData = oData;
                finished = 1'b1;
            end
        end
        @(posedge Clk);
    endtask

    task automatic writeWord(input word_t address, input word_t data);
        access(1'b1, address, data);
        modelWrite(address, data);
    endtask

    task automatic readWord(input word_t address);
        access(1'b0, address, '0);
        checkValue($sformatf("oData[0x%08h]", address), lastData, expectedRead(address));
    endtask

    task automatic idleCycles(input int cycles);
        @(negedge Clk);
        en  = 1'b0;
        req = '0;
        repeat (cycles) begin
            #(Period / 4);
            checkValue("stall", word_t'(stall), '0);
            checkValue("oData", oData, '0);
            @(negedge Clk);
        end
    endtask

    ////////////////////
    // Tests

    task automatic testMemRoundTrip();
        word_t addrs [6];
        // 0x100 and 0x200 share cache index 0 with different tags
        addrs = '{32'h0000_0100, 32'h0000_0104, 32'h0000_03F0,
                  32'h0000_0200, 32'h0000_7FFC, 32'h0003_0008};
        foreach (addrs[i]) begin
            writeWord(addrs[i], 32'hC0DE_0000 | word_t'(i));
        end
        foreach (addrs[i]) begin
            readWord(addrs[i]);
        end
        readWord(32'h0000_0100);
        readWord(32'h0000_0200);
        readWord(32'h0000_0100);
        // Write hit must update the cached line
        writeWord(32'h0000_0100, 32'h5A5A_0100);
        readWord(32'h0000_0100);
    endtask

    task automatic testHitMiss();
        writeWord(32'h0000_0A40, 32'h1234_5678);
        readWord(32'h0000_0A40);
        expectTrue(lastSawStall, "read miss at 0x00000A40 completed without a stall");
        readWord(32'h0000_0A40);
        expectTrue(!lastSawStall && lastCycles == 1,
            "read hit at 0x00000A40 did not complete in its first cycle");
    endtask

    task automatic testPeriphRoundTrip();
        for (int i = 0; i < 8; i++) begin
            writeWord(PeriphBase + 4 * i, 32'hBEEF_0000 + i);
            expectTrue(lastSawStall, "peripheral write completed without a stall");
        end
        for (int i = 0; i < 8; i++) begin
            readWord(PeriphBase + 4 * i);
            expectTrue(lastSawStall, "peripheral read completed without a stall");
            // Same register through a higher alias
            readWord(PeriphBase + 32'h40 + 4 * i);
            expectTrue(lastSawStall, "aliased peripheral read completed without a stall");
        end
    endtask

    task automatic testBoundaries();
        writeWord(32'h0000_FFFC, 32'hFFFC_0001);
        writeWord(32'h0002_0004, 32'h2000_4001);
        writeWord(32'h0001_0000, 32'h1000_0001);
        writeWord(32'h0002_0000, 32'h2000_0001);
        readWord(32'h0000_FFFC);
        readWord(32'h0002_0004);
        readWord(32'h0002_0000);
        readWord(32'h0001_0000);
        checkValue("oData[0x00010000]", lastData, 32'h2000_0001);
        // Lower memory aliases of 0xFFFC and 0x20004
        readWord(32'h0000_0FFC);
        checkValue("oData[0x00000FFC]", lastData, 32'hFFFC_0001);
        readWord(32'h0000_0004);
        checkValue("oData[0x00000004]", lastData, 32'h2000_4001);
        // Memory word at the same index as 0x20000
        readWord(32'h0000_0000);
        checkValue("oData[0x00000000]", lastData, 32'h0000_0000);
    endtask

    task automatic testRandomMix();
        word_t address;
        logic  isWrite;
        repeat (RandomOps) begin
            isWrite = randomBits(1) != 0;
            if (randomBits(1) != 0) begin
                address = PeriphBase + (randomBits(14) << 2);
            end else begin
                address = (randomBits(14) << 2) + ((randomBits(1) != 0) ? 32'h0004_0000 : 0);
            end
            if (isWrite) begin
                writeWord(address, randomBits(32));
            end else begin
                readWord(address);
            end
        end
    endtask

    ////////////////////
    // Main sequence

    initial begin
        Clk       = 1'b0;
        reset     = 1'b1;
        en        = 1'b0;
        req       = '0;
        lfsrState = 16'd10;
        errors    = 0;
        checks    = 0;
        foreach (periphModel[i]) begin
            periphModel[i] = '0;
        end
        foreach (memModel[i]) begin
            memModel[i] = '0;
        end
        repeat (8) @(posedge Clk);
        @(negedge Clk);
        reset = 1'b0;

        idleCycles(4);
        testMemRoundTrip();
        testHitMiss();
        testPeriphRoundTrip();
        testBoundaries();
        idleCycles(4);
        testRandomMix();
        idleCycles(4);

        $display("Checks: %0d, errors: %0d", checks, errors);
        if (errors == 0) begin
            $display("STATUS: PASS");
        end else begin
            $display("STATUS: FAIL");
        end
        $finish;
    end

    // Watchdog sized for the worst access latency plus a margin
    initial begin
        #(NumAccesses * (MemLatency + PeriphLatency + 10) * Period + 200 * Period);
        $display("Timeout: the run did not finish, %0d errors so far", errors);
        $display("STATUS: FAIL");
        $finish;
    end

endmodule

//--- tb.f
source/memSysPkg.sv
source/memController.sv
source/periphController.sv
source/periphRegBlock.sv
source/dataCache.sv
source/mainMemory.sv
source/memSubsystem.sv
bench/memSubsystemTb.sv
